/* sim.f */
fetch_pkg.sv
bus_pkg.sv
pc_select.sv
fetch_ctrl.sv
txn_counter.sv
prefetch_fifo.sv
if_stage.sv
if_stage_properties.sv
tb_if_stage.sv

/* Bender.yml */
package:
  name: if_stage

sources:
  - fetch_pkg.sv
  - bus_pkg.sv
  - pc_select.sv
  - fetch_ctrl.sv
  - txn_counter.sv
  - prefetch_fifo.sv
  - if_stage.sv
  - target: test
    files:
      - if_stage_properties.sv
      - tb_if_stage.sv

/* tb_if_stage.sv */
`timescale 1ns/1ps

module tb_if_stage import fetch_pkg::*, bus_pkg::*; ();

  // Words in this range come back with a bus error
  localparam addr_t ERR_LO  = 32'h0000_3000;
  localparam addr_t ERR_HI  = 32'h0000_3010;
  localparam int    TIMEOUT = 400;

  logic        clk;
  logic        rst_n;
  ctrl_fetch_t ctrl;
  addr_t       boot_addr;
  addr_t       jump_target;
  addr_t       branch_target;
  addr_t       mepc;
  mtvec_t      mtvec_addr;
  logic        bus_req;
  bus_req_t    bus_addr;
  logic        bus_gnt;
  logic        bus_rvalid;
  bus_resp_t   bus_resp;
  logic        id_ready;
  logic        if_valid;
  if_id_pipe_t if_id_pipe;
  addr_t       pc_if;
  logic        if_busy;
  logic        csr_mtvec_init;

  // Bus and decode model state
  addr_t       grant_q [$];
  logic        bus_random;
  logic        ready_random;
  logic        ready_level;
  int          seed;
  int          bus_seed;
  int          ready_seed;
  int          halt_seed;

  // Expected stream
  addr_t       exp_pc;
  if_id_pipe_t exp_entry;
  if_id_pipe_t prev_pipe;
  logic        prev_ready;
  logic        prev_valid;
  logic        pipe_known;
  logic        first_pending;
  addr_t       first_pc;
  int          accept_count;
  int          err_seen;
  int          error_count;
  int          timeout_count;

  if_stage i_if_stage (
    .clk              (clk),
    .rst_n            (rst_n),
    .ctrl_i           (ctrl),
    .boot_addr_i      (boot_addr),
    .jump_target_i    (jump_target),
    .branch_target_i  (branch_target),
    .mepc_i           (mepc),
    .mtvec_addr_i     (mtvec_addr),
    .bus_req_o        (bus_req),
    .bus_addr_o       (bus_addr),
    .bus_gnt_i        (bus_gnt),
    .bus_rvalid_i     (bus_rvalid),
    .bus_resp_i       (bus_resp),
    .id_ready_i       (id_ready),
    .if_valid_o       (if_valid),
    .if_id_pipe_o     (if_id_pipe),
    .pc_if_o          (pc_if),
    .if_busy_o        (if_busy),
    .csr_mtvec_init_o (csr_mtvec_init)
  );

  bind if_stage if_stage_properties i_if_stage_properties (
    .clk           (clk),
    .rst_n         (rst_n),
    .bus_req_i     (bus_req_o),
    .bus_gnt_i     (bus_gnt_i),
    .bus_addr_i    (bus_addr_o),
    .bus_rvalid_i  (bus_rvalid_i),
    .id_ready_i    (id_ready_i),
    .if_id_pipe_i  (if_id_pipe_o),
    .outstanding_i (outstanding)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // Models
  //////////////////////////////

  // Memory word, address rotated left by 8 and scrambled
  function automatic instr_t model_word(input addr_t addr);
    return {addr[23:0], addr[31:24]} ^ 32'h5A3C_96E1;
  endfunction

  function automatic logic in_err_window(input addr_t addr);
    return (addr >= ERR_LO) && (addr < ERR_HI);
  endfunction

  // Grants recorded mid cycle, in-order responses a cycle or more later
  initial begin : bus_model
    addr_t resp_addr;
    forever begin
      @(posedge clk);
      #1;
      bus_rvalid = 1'b0;
      bus_resp   = '0;
      bus_gnt    = bus_random ? (($random(bus_seed) & 3) != 0) : 1'b1;
      if (rst_n && (grant_q.size() > 0) && (!bus_random || (($random(bus_seed) & 1) != 0))) begin
        resp_addr  = grant_q.pop_front();
        bus_rvalid = 1'b1;
        bus_resp   = '{rdata: model_word(resp_addr), err: in_err_window(resp_addr)};
      end
      @(negedge clk);
      if (rst_n && bus_req && bus_gnt) begin
        grant_q.push_back(bus_addr.addr);
      end
    end
  end

  // Decode side ready, random gaps or a fixed level
  initial begin : decode_model
    forever begin
      @(posedge clk);
      #1;
      id_ready = ready_random ? (($random(ready_seed) % 3) != 0) : ready_level;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic compare_pipe(input if_id_pipe_t got, input if_id_pipe_t exp, input string msg);
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t: %s, got v%b %h pc %h err %b, expected v%b %h pc %h err %b",
               $time, msg, got.instr_valid, got.instr, got.pc, got.bus_err,
               exp.instr_valid, exp.instr, exp.pc, exp.bus_err);
    end
  endtask

  task automatic compare_addr(input addr_t got, input addr_t exp, input string msg);
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t: %s, got %b expected %b", $time, msg, got, exp);
    end
  endtask

  // Follows every acceptance and the pipe register one cycle later
  initial begin : accept_monitor
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        pipe_known = 1'b0;
      end else begin
        if (pipe_known && prev_ready && prev_valid) begin
          compare_pipe(if_id_pipe, exp_entry, "accepted instruction in pipe");
          if (if_id_pipe.bus_err) begin
            err_seen++;
          end
        end else if (pipe_known && prev_ready) begin
          compare_bit(if_id_pipe.instr_valid, 1'b0, "pipe valid with nothing handed over");
        end else if (pipe_known) begin
          compare_pipe(if_id_pipe, prev_pipe, "pipe held under stall");
        end
        if (ctrl.halt_if) begin
          compare_bit(if_valid, 1'b0, "if_valid under halt");
        end
        if (if_valid && id_ready) begin
          compare_addr(pc_if, exp_pc, "accepted pc");
          if (first_pending) begin
            first_pc      = pc_if;
            first_pending = 1'b0;
          end
          exp_entry = '{instr_valid: 1'b1, instr: model_word(exp_pc), pc: exp_pc,
                        bus_err: in_err_window(exp_pc)};
          exp_pc    = exp_pc + 32'd4;
          accept_count++;
        end
        prev_pipe  = if_id_pipe;
        prev_ready = id_ready;
        prev_valid = if_valid;
        pipe_known = 1'b1;
      end
    end
  end

  //////////////////////////////
  // Waits and stimulus
  //////////////////////////////

  task automatic wait_accepts(input int n, input string what);
    int target;
    int cycles;
    target = accept_count + n;
    cycles = 0;
    while ((accept_count < target) && (cycles < TIMEOUT)) begin
      @(negedge clk);
      cycles++;
    end
    if (accept_count < target) begin
      timeout_count++;
      $display("Timeout: %s did not deliver %0d instructions in time", what, n);
    end
  endtask

  task automatic wait_in_flight();
    int cycles;
    cycles = 0;
    while ((grant_q.size() == 0) && (cycles < TIMEOUT)) begin
      @(negedge clk);
      cycles++;
    end
    if (grant_q.size() == 0) begin
      timeout_count++;
      $display("Timeout: no bus transaction went outstanding");
    end
  endtask

  // Request raised and left without a grant
  task automatic wait_pending_req();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!(bus_req && !bus_gnt) && (cycles < TIMEOUT)) begin
      @(negedge clk);
      cycles++;
    end
    if (!(bus_req && !bus_gnt)) begin
      timeout_count++;
      $display("Timeout: no bus request waited for its grant");
    end
  endtask

  task automatic wait_head_stalled();
    int cycles;
    cycles = 0;
    while (!(if_valid && !id_ready) && (cycles < TIMEOUT)) begin
      @(negedge clk);
      cycles++;
    end
    if (!(if_valid && !id_ready)) begin
      timeout_count++;
      $display("Timeout: no instruction waited at the stalled boundary");
    end
  endtask

  task automatic set_modes(input logic bus_rand, input logic ready_rand, input logic level);
    @(negedge clk);
    bus_random   = bus_rand;
    ready_random = ready_rand;
    ready_level  = level;
  endtask

  // Controller redirect, with kill of whatever sits at the boundary
  task automatic redirect(input pc_mux_e mux, input irq_id_t irq, input addr_t src,
                          input addr_t target);
    @(posedge clk);
    #1;
    case (mux)
      PC_BOOT:   boot_addr     = src;
      PC_JUMP:   jump_target   = src;
      PC_BRANCH: branch_target = src;
      PC_MRET:   mepc          = src;
      default:   ;
    endcase
    ctrl.pc_set   = 1'b1;
    ctrl.pc_mux   = mux;
    ctrl.irq_id   = irq;
    ctrl.kill_if  = 1'b1;
    exp_pc        = target;
    first_pending = 1'b1;
    @(negedge clk);
    compare_bit(csr_mtvec_init, mux == PC_BOOT, "csr_mtvec_init during pc_set");
    @(posedge clk);
    #1;
    ctrl.pc_set  = 1'b0;
    ctrl.kill_if = 1'b0;
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  // Boot target loses its low bits
  task automatic boot_and_stream();
    set_modes(1'b0, 1'b0, 1'b1);
    redirect(PC_BOOT, '0, 32'h0000_1002, 32'h0000_1000);
    wait_accepts(8, "boot stream");
    // Fetch unit left idle at the first redirect
    compare_bit(if_busy, 1'b1, "if_busy while streaming");
    compare_addr(first_pc, 32'h0000_1000, "first pc after boot");
  endtask

  task automatic jump_and_branch();
    set_modes(1'b1, 1'b1, 1'b1);
    wait_accepts(4, "stream before jump");
    wait_in_flight();
    redirect(PC_JUMP, '0, 32'h0000_2000, 32'h0000_2000);
    wait_accepts(6, "jump stream");
    compare_addr(first_pc, 32'h0000_2000, "first pc after jump");
    // Redirect on top of a request still waiting for its grant
    wait_pending_req();
    redirect(PC_BRANCH, '0, 32'h0000_2400, 32'h0000_2400);
    wait_accepts(6, "branch stream");
    compare_addr(first_pc, 32'h0000_2400, "first pc after branch");
  endtask

  // Vector base 0xC0 << 7 is 0x6000
  task automatic trap_and_return();
    set_modes(1'b0, 1'b0, 1'b1);
    redirect(PC_TRAP_EXC, '0, '0, 32'h0000_6000);
    wait_accepts(3, "exception handler");
    compare_addr(first_pc, 32'h0000_6000, "first pc after exception");
    redirect(PC_TRAP_IRQ, 5'd5, '0, 32'h0000_6014);
    wait_accepts(3, "interrupt handler");
    compare_addr(first_pc, 32'h0000_6014, "first pc after interrupt");
    redirect(PC_MRET, '0, 32'h0000_1240, 32'h0000_1240);
    wait_accepts(3, "return stream");
    compare_addr(first_pc, 32'h0000_1240, "first pc after mret");
  endtask

  task automatic decode_backpressure();
    int i;
    set_modes(1'b0, 1'b1, 1'b1);
    redirect(PC_JUMP, '0, 32'h0000_4000, 32'h0000_4000);
    for (i = 0; i < 60; i++) begin
      @(posedge clk);
      #1;
      ctrl.halt_if = (($random(halt_seed) & 7) == 0);
    end
    @(posedge clk);
    #1;
    ctrl.halt_if = 1'b0;
    wait_accepts(4, "stream after halt pulses");
  endtask

  // Ten words from 0x2FF0, four of them inside the error window
  task automatic bus_stalls_and_errors();
    int errs_before;
    set_modes(1'b1, 1'b0, 1'b1);
    redirect(PC_BRANCH, '0, ERR_LO - 32'd16, ERR_LO - 32'd16);
    errs_before = err_seen;
    wait_accepts(10, "stream across error window");
    compare_bit((err_seen - errs_before) == 4, 1'b1, "four words flagged with bus_err");
  endtask

  task automatic kill_head();
    addr_t killed;
    set_modes(1'b0, 1'b0, 1'b0);
    wait_head_stalled();
    compare_addr(pc_if, exp_pc, "head pc before kill");
    killed = exp_pc;
    @(posedge clk);
    #1;
    ctrl.kill_if = 1'b1;
    exp_pc       = exp_pc + 32'd4;
    @(posedge clk);
    #1;
    ctrl.kill_if  = 1'b0;
    first_pending = 1'b1;
    set_modes(1'b0, 1'b0, 1'b1);
    wait_accepts(3, "stream after kill");
    compare_addr(first_pc, killed + 32'd4, "first pc after kill");
  endtask

  initial begin : main
    seed          = 39;
    bus_seed      = seed;
    ready_seed    = seed + 1;
    halt_seed     = seed + 2;
    rst_n         = 1'b0;
    ctrl          = '0;
    boot_addr     = '0;
    jump_target   = '0;
    branch_target = '0;
    mepc          = '0;
    mtvec_addr    = 25'h00_00C0;
    bus_gnt       = 1'b0;
    bus_rvalid    = 1'b0;
    bus_resp      = '0;
    id_ready      = 1'b1;
    bus_random    = 1'b0;
    ready_random  = 1'b0;
    ready_level   = 1'b1;
    exp_pc        = '0;
    first_pc      = '0;
    first_pending = 1'b0;
    pipe_known    = 1'b0;
    accept_count  = 0;
    err_seen      = 0;
    error_count   = 0;
    timeout_count = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    compare_bit(bus_req, 1'b0, "bus_req in reset");
    compare_bit(if_valid, 1'b0, "if_valid in reset");
    compare_bit(csr_mtvec_init, 1'b0, "csr_mtvec_init in reset");
    compare_bit(if_busy, 1'b0, "if_busy in reset");
    compare_bit(if_id_pipe.instr_valid, 1'b0, "pipe valid in reset");
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    boot_and_stream();
    jump_and_branch();
    trap_and_return();
    decode_backpressure();
    bus_stalls_and_errors();
    kill_head();
    $display("Checks done with %0d value errors and %0d timeouts", error_count, timeout_count);
    if ((error_count == 0) && (timeout_count == 0)) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* if_stage_properties.sv */
`timescale 1ns/1ps

module if_stage_properties import fetch_pkg::*, bus_pkg::*; (
  input logic             clk,
  input logic             rst_n,
  input logic             bus_req_i,
  input logic             bus_gnt_i,
  input bus_req_t         bus_addr_i,
  input logic             bus_rvalid_i,
  input logic             id_ready_i,
  input if_id_pipe_t      if_id_pipe_i,
  input logic [CNT_W-1:0] outstanding_i
);

  // Request stays up with the same address until granted
  req_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_i && !bus_gnt_i |=> bus_req_i && $stable(bus_addr_i))
    else $error("bus request dropped or moved before its grant");

  // Outstanding limit
  outstanding_a: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_i <= CNT_W'(MAX_OUTSTANDING))
    else $error("outstanding count above limit");

  // IF/ID register frozen while decode stalls
  pipe_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    !id_ready_i |=> $stable(if_id_pipe_i))
    else $error("pipe register changed while decode stalled");

  rvalid_a: assert property (@(posedge clk) disable iff (!rst_n)
    bus_rvalid_i |-> (outstanding_i != '0))
    else $error("response with no transaction outstanding");

endmodule

/* if_stage.sv */
`timescale 1ns/1ps

module if_stage import fetch_pkg::*, bus_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  ctrl_fetch_t ctrl_i,
  // Redirect targets
  input  addr_t       boot_addr_i,
  input  addr_t       jump_target_i,
  input  addr_t       branch_target_i,
  input  addr_t       mepc_i,
  input  mtvec_t      mtvec_addr_i,
  // Instruction bus
  output logic        bus_req_o,
  output bus_req_t    bus_addr_o,
  input  logic        bus_gnt_i,
  input  logic        bus_rvalid_i,
  input  bus_resp_t   bus_resp_i,
  // Decode handshake
  input  logic        id_ready_i,
  output logic        if_valid_o,
  output if_id_pipe_t if_id_pipe_o,
  output addr_t       pc_if_o,
  output logic        if_busy_o,
  output logic        csr_mtvec_init_o
);

  addr_t            redirect_addr;
  addr_t            fetch_addr;
  logic             room;
  logic             keep;
  logic             fetch_busy;
  logic [CNT_W-1:0] outstanding;
  logic [CNT_W-1:0] fifo_count;
  fetch_entry_t     head;
  logic             head_valid;
  logic             bus_grant;
  logic             flush;
  logic             pop;
  // Request held over a redirect, its response is stale
  logic             stale_q;
  logic             pipe_valid_q;
  fetch_entry_t     pipe_entry_q;

  pc_select i_pc_select (
    .ctrl_i          (ctrl_i),
    .boot_addr_i     (boot_addr_i),
    .jump_target_i   (jump_target_i),
    .branch_target_i (branch_target_i),
    .mepc_i          (mepc_i),
    .mtvec_addr_i    (mtvec_addr_i),
    .redirect_addr_o (redirect_addr)
  );

  fetch_ctrl i_fetch_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc_set_i        (ctrl_i.pc_set),
    .redirect_addr_i (redirect_addr),
    .room_i          (room),
    .bus_gnt_i       (bus_gnt_i),
    .bus_req_o       (bus_req_o),
    .bus_addr_o      (bus_addr_o),
    .fetch_addr_o    (fetch_addr),
    .busy_o          (fetch_busy)
  );

  txn_counter i_txn_counter (
    .clk           (clk),
    .rst_n         (rst_n),
    .grant_i       (bus_grant),
    .rvalid_i      (bus_rvalid_i),
    .flush_i       (flush),
    .fifo_count_i  (fifo_count),
    .room_o        (room),
    .keep_o        (keep),
    .outstanding_o (outstanding)
  );

  prefetch_fifo i_prefetch_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .grant_i      (bus_grant),
    .grant_addr_i (fetch_addr),
    .push_i       (keep),
    .resp_i       (bus_resp_i),
    .pop_i        (pop),
    .flush_i      (flush),
    .head_o       (head),
    .valid_o      (head_valid),
    .count_o      (fifo_count)
  );

  //////////////////////////////
  // Flush and handshake
  //////////////////////////////

  assign bus_grant = bus_req_o && bus_gnt_i;
  // Grant of a held request counts as part of the flushed stream
  assign flush     = ctrl_i.pc_set || (stale_q && bus_grant);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stale_q <= 1'b0;
    end else if (ctrl_i.pc_set && bus_req_o && !bus_gnt_i) begin
      stale_q <= 1'b1;
    end else if (bus_grant) begin
      stale_q <= 1'b0;
    end
  end

  assign if_valid_o       = head_valid && !ctrl_i.kill_if && !ctrl_i.halt_if;
  // Kill drops the head without decode taking it
  assign pop              = (if_valid_o && id_ready_i) || (ctrl_i.kill_if && head_valid);
  assign pc_if_o          = head.addr;
  assign if_busy_o        = fetch_busy || (outstanding != '0);
  assign csr_mtvec_init_o = ctrl_i.pc_set && (ctrl_i.pc_mux == PC_BOOT);

  //////////////////////////////
  // IF/ID pipeline register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pipe_valid_q <= 1'b0;
    end else if (id_ready_i) begin
      // Decode ready, valid follows what was handed over
      pipe_valid_q <= if_valid_o;
    end
  end

  // Frozen while decode stalls
  always_ff @(posedge clk) begin
    if (if_valid_o && id_ready_i) begin
      pipe_entry_q <= head;
    end
  end

  always_comb begin
    if_id_pipe_o.instr_valid = pipe_valid_q;
    if_id_pipe_o.instr       = pipe_entry_q.instr;
    if_id_pipe_o.pc          = pipe_entry_q.addr;
    if_id_pipe_o.bus_err     = pipe_entry_q.err;
  end

endmodule

/* prefetch_fifo.sv */
`timescale 1ns/1ps

module prefetch_fifo import fetch_pkg::*, bus_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             grant_i,
  input  addr_t            grant_addr_i,
  input  logic             push_i,
  input  bus_resp_t        resp_i,
  input  logic             pop_i,
  input  logic             flush_i,
  output fetch_entry_t     head_o,
  output logic             valid_o,
  output logic [CNT_W-1:0] count_o
);

  // Addresses of granted fetches, oldest first
  addr_t              aq_mem [MAX_OUTSTANDING];
  logic [AQ_PTR_W-1:0] aq_wr_q, aq_rd_q;

  // Entry ring
  fetch_entry_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               do_pop;

  assign valid_o = (count_q != '0);
  assign count_o = count_q;
  assign head_o  = mem[rd_ptr_q];
  // Popping an empty ring is ignored
  assign do_pop  = pop_i && valid_o;

  //////////////////////////////
  // Pointers and fill level
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aq_wr_q  <= '0;
      aq_rd_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // Old stream gone, discarded fetches leave no queued address
      aq_wr_q  <= '0;
      aq_rd_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (grant_i) begin
        aq_wr_q <= aq_wr_q + 1'b1;
      end
      if (push_i) begin
        aq_rd_q  <= aq_rd_q + 1'b1;
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push_i) - CNT_W'(do_pop);
    end
  end

  //////////////////////////////
  // Storage
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (grant_i) begin
      aq_mem[aq_wr_q] <= grant_addr_i;
    end
    // Response joins the address queued at its grant
    if (push_i) begin
      mem[wr_ptr_q] <= '{instr: resp_i.rdata, addr: aq_mem[aq_rd_q], err: resp_i.err};
    end
  end

endmodule

/* txn_counter.sv */
`timescale 1ns/1ps

module txn_counter import fetch_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             grant_i,
  input  logic             rvalid_i,
  input  logic             flush_i,
  input  logic [CNT_W-1:0] fifo_count_i,
  output logic             room_o,
  output logic             keep_o,
  output logic [CNT_W-1:0] outstanding_o
);

  logic [CNT_W-1:0] outstanding_q, outstanding_n;
  // Responses still owed to a flushed stream
  logic [CNT_W-1:0] discard_q;
  // Bus slots plus buffer slots in use
  logic [CNT_W:0]   fill;

  assign outstanding_n = outstanding_q + CNT_W'(grant_i) - CNT_W'(rvalid_i);
  assign fill          = {1'b0, outstanding_q} + {1'b0, fifo_count_i};

  // Every issued fetch must find a free buffer slot
  assign room_o        = (outstanding_q < MAX_OUTSTANDING) && (fill < FIFO_DEPTH);
  assign keep_o        = rvalid_i && (discard_q == '0);
  assign outstanding_o = outstanding_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
      discard_q     <= '0;
    end else begin
      outstanding_q <= outstanding_n;
      if (flush_i) begin
        // Whatever is left on the bus belongs to the old stream
        discard_q <= outstanding_n;
      end else if (rvalid_i && (discard_q != '0)) begin
        discard_q <= discard_q - 1'b1;
      end
    end
  end

endmodule

/* fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl import fetch_pkg::*, bus_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     pc_set_i,
  input  addr_t    redirect_addr_i,
  input  logic     room_i,
  input  logic     bus_gnt_i,
  output logic     bus_req_o,
  output bus_req_t bus_addr_o,
  output addr_t    fetch_addr_o,
  output logic     busy_o
);

  fetch_state_e state_q, state_n;
  addr_t        fetch_addr_q, fetch_addr_n;
  // Old request address held across a redirect
  addr_t        hold_addr_q;
  // Request was high last cycle without a grant
  logic         pend_q;
  logic         grant;

  //////////////////////////////
  // Bus request
  //////////////////////////////

  // A pending request must stay up, new ones need room and no redirect
  always_comb begin
    unique case (state_q)
      FETCH:      bus_req_o = pend_q || (room_i && !pc_set_i);
      WAIT_FLUSH: bus_req_o = 1'b1;
      default:    bus_req_o = 1'b0;
    endcase
  end

  assign grant = bus_req_o && bus_gnt_i;

  // Stale address while waiting out the held request
  assign bus_addr_o.addr = (state_q == WAIT_FLUSH) ? hold_addr_q : fetch_addr_q;
  assign fetch_addr_o    = fetch_addr_q;
  assign busy_o          = (state_q != IDLE);

  //////////////////////////////
  // Next state and address
  //////////////////////////////

  always_comb begin
    state_n      = state_q;
    fetch_addr_n = fetch_addr_q;
    unique case (state_q)
      IDLE: begin
        if (pc_set_i) begin
          state_n      = FETCH;
          fetch_addr_n = redirect_addr_i;
        end
      end
      FETCH: begin
        if (pc_set_i) begin
          fetch_addr_n = redirect_addr_i;
          // Ungranted request has to be carried to its grant
          if (bus_req_o && !bus_gnt_i) begin
            state_n = WAIT_FLUSH;
          end
        end else if (grant) begin
          fetch_addr_n = fetch_addr_q + 32'd4;
        end
      end
      WAIT_FLUSH: begin
        // A later redirect only replaces the target
        if (pc_set_i) begin
          fetch_addr_n = redirect_addr_i;
        end
        if (bus_gnt_i) begin
          state_n = FETCH;
        end
      end
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      fetch_addr_q <= '0;
      pend_q       <= 1'b0;
    end else begin
      state_q      <= state_n;
      fetch_addr_q <= fetch_addr_n;
      pend_q       <= bus_req_o && !bus_gnt_i;
    end
  end

  // Capture the address of the request left hanging
  always_ff @(posedge clk) begin
    if ((state_q == FETCH) && (state_n == WAIT_FLUSH)) begin
      hold_addr_q <= fetch_addr_q;
    end
  end

endmodule

/* pc_select.sv */
`timescale 1ns/1ps

module pc_select import fetch_pkg::*; (
  input  ctrl_fetch_t ctrl_i,
  input  addr_t       boot_addr_i,
  input  addr_t       jump_target_i,
  input  addr_t       branch_target_i,
  input  addr_t       mepc_i,
  input  mtvec_t      mtvec_addr_i,
  output addr_t       redirect_addr_o
);

  addr_t boot_aligned;
  addr_t trap_exc_addr;
  addr_t trap_irq_addr;

  // Boot target forced to a word boundary
  assign boot_aligned  = {boot_addr_i[31:2], 2'b00};

  // All exceptions land on the vector base
  assign trap_exc_addr = {mtvec_addr_i, 7'h00};

  // Interrupts are vectored, base plus four times the index
  assign trap_irq_addr = {mtvec_addr_i, ctrl_i.irq_id, 2'b00};

  //////////////////////////////
  // Redirect target mux
  //////////////////////////////

  always_comb begin
    // Boot as the fallback for unused codes
    redirect_addr_o = boot_aligned;
    unique case (ctrl_i.pc_mux)
      PC_BOOT:     redirect_addr_o = boot_aligned;
      PC_JUMP:     redirect_addr_o = jump_target_i;
      PC_BRANCH:   redirect_addr_o = branch_target_i;
      // Return from trap restores the saved pc
      PC_MRET:     redirect_addr_o = mepc_i;
      PC_TRAP_EXC: redirect_addr_o = trap_exc_addr;
      PC_TRAP_IRQ: redirect_addr_o = trap_irq_addr;
      default:     redirect_addr_o = boot_aligned;
    endcase
  end

endmodule

/* bus_pkg.sv */
package bus_pkg;

  // Address type is shared with the fetch side
  import fetch_pkg::*;

  //////////////////////////////
  // Instruction bus payloads
  //////////////////////////////

  // Request payload, qualified by req/gnt
  typedef struct packed {
    addr_t addr;
  } bus_req_t;

  // Response payload, qualified by rvalid, 33 bits
  typedef struct packed {
    instr_t rdata;
    // Bus error for this word
    logic   err;
  } bus_resp_t;

endpackage

/* fetch_pkg.sv */
package fetch_pkg;

  //////////////////////////////
  // Widths with a meaning
  //////////////////////////////

  // Byte address and instruction word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  // Trap vector base, address bits 31 to 7
  typedef logic [24:0] mtvec_t;
  // Interrupt index for vectored traps
  typedef logic [4:0]  irq_id_t;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_BRANCH,
    PC_MRET,
    PC_TRAP_EXC,
    PC_TRAP_IRQ
  } pc_mux_e;

  // Fetch controller states
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    WAIT_FLUSH
  } fetch_state_e;

  //////////////////////////////
  // Bundles
  //////////////////////////////

  // Controller to fetch stage, 11 bits
  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
    irq_id_t irq_id;
    logic    kill_if;
    logic    halt_if;
  } ctrl_fetch_t;

  // One buffered fetch, 65 bits
  typedef struct packed {
    instr_t instr;
    addr_t  addr;
    logic   err;
  } fetch_entry_t;

  // IF/ID pipeline register, 66 bits
  typedef struct packed {
    logic   instr_valid;
    instr_t instr;
    addr_t  pc;
    logic   bus_err;
  } if_id_pipe_t;

  // Buffer sizing
  localparam int FIFO_DEPTH      = 2;
  localparam int MAX_OUTSTANDING = 2;
  localparam int CNT_W           = 2;
  localparam int PTR_W           = $clog2(FIFO_DEPTH);
  localparam int AQ_PTR_W        = $clog2(MAX_OUTSTANDING);

endpackage
